// File: design/node_cfg_pkg.sv
/*
 * Node memory configuration
 * Store depths, entry widths and the address and data widths
 * of the merged dual-port RAM
 */
package node_cfg_pkg;

    // Instruction store
    localparam int INSTR_WIDTH = 15;
    localparam int MAX_INSTRS  = 32;

    // Control block
    localparam int CTRL_WIDTH = 13;
    localparam int MAX_CTRL   = 32;

    // Derived address widths
    localparam int INSTR_ADDR_W = $clog2(MAX_INSTRS);
    localparam int CTRL_ADDR_W  = $clog2(MAX_CTRL);

    // Merged RAM, top address bit picks the store
    localparam int RAM_ADDR_W = ((INSTR_ADDR_W > CTRL_ADDR_W) ? INSTR_ADDR_W : CTRL_ADDR_W) + 1;
    localparam int RAM_DATA_W = (INSTR_WIDTH > CTRL_WIDTH) ? INSTR_WIDTH : CTRL_WIDTH;

endpackage : node_cfg_pkg

// File: design/node_msg_pkg.sv
/*
 * Node message types
 * Command encoding of inbound messages plus the instruction,
 * control entry and address types carried between the blocks
 */
package node_msg_pkg;

    import node_cfg_pkg::*;

    // Inbound command field
    typedef enum logic [1:0] {
        CMD_LOAD    = 2'd0,
        CMD_CTRL_WR = 2'd1,
        CMD_CTRL_RD = 2'd2,
        CMD_RUN     = 2'd3
    } cmd_e;

    // Payload types
    typedef logic [INSTR_WIDTH-1:0] instr_t;
    typedef logic [CTRL_WIDTH-1:0]  ctrl_t;

    // Store addresses
    typedef logic [INSTR_ADDR_W-1:0] instr_addr_t;
    typedef logic [CTRL_ADDR_W-1:0]  ctrl_addr_t;

    // Inbound message, 22 bits
    // Address is only meaningful for control commands
    typedef struct packed {
        cmd_e       cmd;
        ctrl_addr_t addr;
        instr_t     data;
    } node_msg_t;

endpackage : node_msg_pkg

// File: design/node_if.sv
/*
 * Node internal links
 * fetch_if carries instruction fetches from the sequencer to the store,
 * ctrl_if carries control block reads and writes from the decoder
 */
`timescale 1ns/1ps

interface fetch_if import node_msg_pkg::*; ();

    // Request side
    instr_addr_t addr;
    logic        rd;

    // Store side
    instr_t      data;
    logic        stall;
    instr_addr_t count;

    modport store (
        input  addr, rd,
        output data, stall, count
    );

    modport sequencer (
        output addr, rd,
        input  data, stall, count
    );

endinterface : fetch_if

interface ctrl_if import node_msg_pkg::*; ();

    ctrl_addr_t addr;
    ctrl_t      wr_data;
    logic       wr_en;
    logic       rd_en;
    // Valid one cycle after rd_en
    ctrl_t      rd_data;

    modport decoder (
        output addr, wr_data, wr_en, rd_en,
        input  rd_data
    );

    modport store (
        input  addr, wr_data, wr_en, rd_en,
        output rd_data
    );

endinterface : ctrl_if

// File: design/node_ram.sv
/*
 * Dual-port synchronous RAM
 * Two independent ports on one clock, each with enable and write enable
 * Registered reads return the old word on a write to the same address
 */
`timescale 1ns/1ps

module node_ram #(
    parameter int ADDRESS_WIDTH = 6,
    parameter int DATA_WIDTH    = 15
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    // Port A
    input  logic [ADDRESS_WIDTH-1:0] addr_a_i,
    input  logic [DATA_WIDTH-1:0]    wr_data_a_i,
    input  logic                     wr_en_a_i,
    input  logic                     en_a_i,
    output logic [DATA_WIDTH-1:0]    rd_data_a_o,
    // Port B
    input  logic [ADDRESS_WIDTH-1:0] addr_b_i,
    input  logic [DATA_WIDTH-1:0]    wr_data_b_i,
    input  logic                     wr_en_b_i,
    input  logic                     en_b_i,
    output logic [DATA_WIDTH-1:0]    rd_data_b_o
);

    localparam int DEPTH = 1 << ADDRESS_WIDTH;

    logic [DATA_WIDTH-1:0] mem_q [DEPTH];
    logic [DATA_WIDTH-1:0] rd_data_a_q;
    logic [DATA_WIDTH-1:0] rd_data_b_q;

    // Array writes, both ports
    always_ff @(posedge clk_i) begin
        if (en_a_i && wr_en_a_i)
            mem_q[addr_a_i] <= wr_data_a_i;
        if (en_b_i && wr_en_b_i)
            mem_q[addr_b_i] <= wr_data_b_i;
    end

    // Read registers hold their value while the port is idle
    always_ff @(posedge clk_i, posedge rst_i) begin
        if (rst_i) begin
            rd_data_a_q <= '0;
            rd_data_b_q <= '0;
        end else begin
            if (en_a_i)
                rd_data_a_q <= mem_q[addr_a_i];
            if (en_b_i)
                rd_data_b_q <= mem_q[addr_b_i];
        end
    end

    assign rd_data_a_o = rd_data_a_q;
    assign rd_data_b_o = rd_data_b_q;

endmodule : node_ram

// File: design/node_store.sv
/*
 * Node store
 * Instruction and control stores merged into one dual-port RAM
 * Port A serves instruction loads and fetches, port B the control block
 * Loads append at the current count and stall the fetch path
 */
`timescale 1ns/1ps

module node_store
    import node_cfg_pkg::*;
    import node_msg_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,
    // Instruction append
    input  instr_t store_data_i,
    input  logic   store_valid_i,
    // Fetch and control links
    fetch_if.store fetch,
    ctrl_if.store  ctrl
);

    // Number of stored instructions, also the next load address
    instr_addr_t count_q;

    instr_addr_t           instr_addr;
    logic [RAM_ADDR_W-1:0] ram_addr_a;
    logic [RAM_ADDR_W-1:0] ram_addr_b;
    logic [RAM_DATA_W-1:0] rd_data_a;
    logic [RAM_DATA_W-1:0] rd_data_b;

    // A load takes port A over the fetch
    assign instr_addr = store_valid_i ? count_q : fetch.addr;

    // Lower half for instructions, upper half for control
    assign ram_addr_a = RAM_ADDR_W'(instr_addr);
    assign ram_addr_b = {1'b1, (RAM_ADDR_W-1)'(ctrl.addr)};

    node_ram #(
        .ADDRESS_WIDTH(RAM_ADDR_W),
        .DATA_WIDTH   (RAM_DATA_W)
    ) u_ram (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .addr_a_i   (ram_addr_a),
        .wr_data_a_i(RAM_DATA_W'(store_data_i)),
        .wr_en_a_i  (store_valid_i),
        .en_a_i     (store_valid_i || fetch.rd),
        .rd_data_a_o(rd_data_a),
        .addr_b_i   (ram_addr_b),
        .wr_data_b_i(RAM_DATA_W'(ctrl.wr_data)),
        .wr_en_b_i  (ctrl.wr_en),
        .en_b_i     (ctrl.wr_en || ctrl.rd_en),
        .rd_data_b_o(rd_data_b)
    );

    // Trim merged words back to each store width
    assign fetch.data   = rd_data_a[INSTR_WIDTH-1:0];
    assign ctrl.rd_data = rd_data_b[CTRL_WIDTH-1:0];

    // Port A busy with a load
    assign fetch.stall = store_valid_i;
    assign fetch.count = count_q;

    // Append counter, wraps at store depth
    always_ff @(posedge clk_i, posedge rst_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (store_valid_i) begin
            count_q <= count_q + instr_addr_t'(1);
        end
    end

endmodule : node_store

// File: design/msg_decoder.sv
/*
 * Message decoder
 * Registers each inbound message and turns its command into one strobe
 * Also captures returning control data and flags it as valid
 */
`timescale 1ns/1ps

module msg_decoder
    import node_cfg_pkg::*;
    import node_msg_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  node_msg_t msg_i,
    input  logic      msg_valid_i,
    // Instruction append
    output instr_t    store_data_o,
    output logic      store_valid_o,
    // Control block
    ctrl_if.decoder   ctrl,
    // Run request pulse
    output logic      run_start_o,
    // Control read result
    output logic      ctrl_rd_valid_o,
    output ctrl_t     ctrl_rd_data_o
);

    logic load_d, wr_d, rd_d, run_d;
    logic load_q, wr_q, rd_q, run_q;
    // Read strobe delayed to line up with RAM output
    logic rd_pend_q;
    logic rd_valid_q;

    ctrl_addr_t addr_q;
    instr_t     data_q;
    ctrl_t      rd_data_q;

    // One strobe per accepted message
    always_comb begin
        load_d = 1'b0;
        wr_d   = 1'b0;
        rd_d   = 1'b0;
        run_d  = 1'b0;
        if (msg_valid_i) begin
            case (msg_i.cmd)
                CMD_LOAD:    load_d = 1'b1;
                CMD_CTRL_WR: wr_d   = 1'b1;
                CMD_CTRL_RD: rd_d   = 1'b1;
                CMD_RUN:     run_d  = 1'b1;
                default:     load_d = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk_i, posedge rst_i) begin
        if (rst_i) begin
            load_q     <= 1'b0;
            wr_q       <= 1'b0;
            rd_q       <= 1'b0;
            run_q      <= 1'b0;
            rd_pend_q  <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            load_q     <= load_d;
            wr_q       <= wr_d;
            rd_q       <= rd_d;
            run_q      <= run_d;
            rd_pend_q  <= rd_q;
            rd_valid_q <= rd_pend_q;
        end
    end

    // Message payload and returned control word
    always_ff @(posedge clk_i) begin
        if (msg_valid_i) begin
            addr_q <= msg_i.addr;
            data_q <= msg_i.data;
        end
        if (rd_pend_q)
            rd_data_q <= ctrl.rd_data;
    end

    assign store_data_o  = data_q;
    assign store_valid_o = load_q;

    // Control entries use the low data bits
    assign ctrl.addr    = addr_q;
    assign ctrl.wr_data = data_q[CTRL_WIDTH-1:0];
    assign ctrl.wr_en   = wr_q;
    assign ctrl.rd_en   = rd_q;

    assign run_start_o     = run_q;
    assign ctrl_rd_valid_o = rd_valid_q;
    assign ctrl_rd_data_o  = rd_data_q;

endmodule : msg_decoder

// File: design/instr_sequencer.sv
/*
 * Instruction sequencer
 * Streams stored instructions in load order after a run request
 * One fetch per unstalled cycle, data and index one cycle later
 */
`timescale 1ns/1ps

module instr_sequencer
    import node_msg_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        run_start_i,
    fetch_if.sequencer  fetch,
    output instr_t      instr_o,
    output instr_addr_t instr_index_o,
    output logic        instr_valid_o,
    output logic        busy_o
);

    logic        busy_q;
    // Next instruction to fetch
    instr_addr_t ptr_q;
    // Fetch in flight, delivered this cycle
    logic        pend_valid_q;
    instr_addr_t pend_idx_q;

    logic fetch_go;

    // Count is sampled per fetch so loads during a run extend it
    assign fetch_go = busy_q && !fetch.stall && (ptr_q < fetch.count);

    assign fetch.rd   = fetch_go;
    assign fetch.addr = ptr_q;

    always_ff @(posedge clk_i, posedge rst_i) begin
        if (rst_i) begin
            busy_q       <= 1'b0;
            ptr_q        <= '0;
            pend_valid_q <= 1'b0;
        end else begin
            pend_valid_q <= fetch_go;
            if (!busy_q) begin
                // Empty store or busy run drops the request
                if (run_start_i && (fetch.count != '0)) begin
                    busy_q <= 1'b1;
                    ptr_q  <= '0;
                end
            end else if (fetch_go) begin
                ptr_q <= ptr_q + instr_addr_t'(1);
            end else if (!fetch.stall) begin
                // Nothing left to fetch
                // Last delivery, if any, is on the outputs now
                busy_q <= 1'b0;
            end
        end
    end

    // Index travels with the request
    always_ff @(posedge clk_i) begin
        if (fetch_go)
            pend_idx_q <= ptr_q;
    end

    // RAM read register feeds the output directly
    assign instr_o       = fetch.data;
    assign instr_index_o = pend_idx_q;
    assign instr_valid_o = pend_valid_q;
    assign busy_o        = busy_q;

endmodule : instr_sequencer

// File: design/node_top.sv
/*
 * Node local memory top level
 * Decoder, merged store and sequencer joined by the fetch
 * and control links, with plain external ports
 */
`timescale 1ns/1ps

module node_top
    import node_msg_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    // Inbound messages
    input  node_msg_t   msg_i,
    input  logic        msg_valid_i,
    // Store status
    output instr_addr_t instr_count_o,
    // Control read result
    output ctrl_t       ctrl_rd_data_o,
    output logic        ctrl_rd_valid_o,
    // Instruction stream
    output instr_t      instr_o,
    output instr_addr_t instr_index_o,
    output logic        instr_valid_o,
    output logic        busy_o
);

    instr_t store_data;
    logic   store_valid;
    logic   run_start;

    fetch_if fetch_bus ();
    ctrl_if  ctrl_bus ();

    msg_decoder u_decoder (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .msg_i          (msg_i),
        .msg_valid_i    (msg_valid_i),
        .store_data_o   (store_data),
        .store_valid_o  (store_valid),
        .ctrl           (ctrl_bus.decoder),
        .run_start_o    (run_start),
        .ctrl_rd_valid_o(ctrl_rd_valid_o),
        .ctrl_rd_data_o (ctrl_rd_data_o)
    );

    node_store u_store (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .store_data_i (store_data),
        .store_valid_i(store_valid),
        .fetch        (fetch_bus.store),
        .ctrl         (ctrl_bus.store)
    );

    instr_sequencer u_sequencer (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .run_start_i  (run_start),
        .fetch        (fetch_bus.sequencer),
        .instr_o      (instr_o),
        .instr_index_o(instr_index_o),
        .instr_valid_o(instr_valid_o),
        .busy_o       (busy_o)
    );

    // Count comes straight from the store
    assign instr_count_o = fetch_bus.count;

endmodule : node_top

// File: sim/node_checker.sv
/*
 * Sequencer checker
 * Fetch and delivery rules of the instruction sequencer
 */
`timescale 1ns/1ps

module node_checker
    import node_msg_pkg::*;
(
    input logic        clk_i,
    input logic        rst_i,
    input logic        stall_i,
    input instr_addr_t count_i,
    input instr_addr_t index_i,
    input logic        instr_valid_i,
    input logic        busy_i
);

    // Port A belongs to the load while stalled
    // So no instruction can arrive one cycle later
    no_fetch_in_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_i |=> !instr_valid_i)
        else $error("Instruction delivered after a stalled cycle");

    // Deliveries only inside a run
    valid_only_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        instr_valid_i |-> busy_i)
        else $error("Instruction delivered outside a run");

    // Delivered index must point into the store
    index_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
        instr_valid_i |-> (index_i < count_i))
        else $error("Delivered index beyond the instruction count");

endmodule : node_checker

// File: sim/node_top_tb.sv
/*
 * Node local memory testbench
 * Table of messages applied in a loop, reference model of the stores
 * and the run stream, compare tasks and a cycle limit
 */
`timescale 1ns/1ps

module node_top_tb
    import node_cfg_pkg::*;
    import node_msg_pkg::*;
();

    typedef struct {
        node_msg_t msg;
        ctrl_t     exp;
        int        gap;
    } entry_t;

    logic        clk_i;
    logic        rst_i;
    node_msg_t   msg_i;
    logic        msg_valid_i;
    instr_addr_t instr_count_o;
    ctrl_t       ctrl_rd_data_o;
    logic        ctrl_rd_valid_o;
    instr_t      instr_o;
    instr_addr_t instr_index_o;
    logic        instr_valid_o;
    logic        busy_o;

    // Stimulus
    entry_t tbl[$];
    ctrl_t  cur_exp;
    int     seed = 8;
    int     cycle_cnt = 0;
    int     cycle_limit = 0;
    logic   mon_en = 1'b0;

    // Reference model
    instr_t model_instrs[$];
    ctrl_t  model_ctrl [MAX_CTRL] = '{default: '0};
    int     model_count = 0;
    logic   model_busy = 1'b0;
    int     next_idx = 0;
    int     prev_count = 0;
    logic   prev_busy = 1'b0;
    logic   run_ok;
    logic   run_new;

    // Message age in cycles, stage 0 is the cycle before sampling
    logic [2:0] load_pipe = '0;
    logic [3:0] rd_pipe = '0;
    ctrl_t      rd_data_pipe [4];
    logic [2:0] run_pipe = '0;
    logic [2:0] run_exp = '0;

    node_top uut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .msg_i          (msg_i),
        .msg_valid_i    (msg_valid_i),
        .instr_count_o  (instr_count_o),
        .ctrl_rd_data_o (ctrl_rd_data_o),
        .ctrl_rd_valid_o(ctrl_rd_valid_o),
        .instr_o        (instr_o),
        .instr_index_o  (instr_index_o),
        .instr_valid_o  (instr_valid_o),
        .busy_o         (busy_o)
    );

    bind instr_sequencer node_checker u_checker (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (fetch.stall),
        .count_i      (fetch.count),
        .index_i      (instr_index_o),
        .instr_valid_i(instr_valid_o),
        .busy_i       (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at first failure");
    endtask

    task automatic check_instr(input instr_t got, input instr_addr_t got_idx,
                               input instr_t exp, input instr_addr_t exp_idx);
        if (got_idx !== exp_idx)
            report_failure($sformatf("ERROR: instr_index_o got 0x%h expected 0x%h",
                                     got_idx, exp_idx));
        if (got !== exp)
            report_failure($sformatf("ERROR: instr_o got 0x%h expected 0x%h", got, exp));
    endtask

    task automatic check_ctrl(input ctrl_t got, input ctrl_t exp);
        if (got !== exp)
            report_failure($sformatf("ERROR: ctrl_rd_data_o got 0x%h expected 0x%h",
                                     got, exp));
    endtask

    task automatic check_count(input instr_addr_t got, input instr_addr_t exp);
        if (got !== exp)
            report_failure($sformatf("ERROR: instr_count_o got 0x%h expected 0x%h",
                                     got, exp));
    endtask

    // Gap of -1 picks a random gap of 0 to 3 cycles
    task automatic add_entry(input cmd_e cmd, input int addr, input int data,
                             input int exp, input int gap);
        entry_t e;
        e.msg.cmd  = cmd;
        e.msg.addr = ctrl_addr_t'(addr);
        e.msg.data = instr_t'(data);
        e.exp      = ctrl_t'(exp);
        e.gap      = gap;
        tbl.push_back(e);
    endtask

    // Expected field: read data for CTRL_RD, acceptance for RUN
    task automatic build_table();
        add_entry(CMD_RUN,     0,  0,      0,      2);
        add_entry(CMD_LOAD,    0,  'h1A01, 0,      -1);
        add_entry(CMD_LOAD,    0,  'h2B02, 0,      0);
        add_entry(CMD_LOAD,    0,  'h3C03, 0,      -1);
        add_entry(CMD_LOAD,    0,  'h4D04, 0,      0);
        add_entry(CMD_LOAD,    0,  'h5E05, 0,      1);
        add_entry(CMD_CTRL_WR, 3,  'h0ABC, 0,      0);
        add_entry(CMD_CTRL_RD, 3,  0,      'h0ABC, 1);
        add_entry(CMD_CTRL_WR, 17, 'h1F0F, 0,      1);
        // Run, then a second RUN while busy
        add_entry(CMD_RUN,     0,  0,      1,      1);
        add_entry(CMD_RUN,     0,  0,      0,      0);
        // Loads and control traffic inside the run
        add_entry(CMD_LOAD,    0,  'h6F06, 0,      0);
        add_entry(CMD_CTRL_RD, 17, 0,      'h1F0F, 0);
        add_entry(CMD_LOAD,    0,  'h7007, 0,      -1);
        add_entry(CMD_CTRL_WR, 3,  'h1555, 0,      0);
        add_entry(CMD_CTRL_RD, 3,  0,      'h1555, 0);
        add_entry(CMD_LOAD,    0,  'h0808, 0,      3);
        // Second full run from index zero
        add_entry(CMD_RUN,     0,  0,      1,      0);
        add_entry(CMD_LOAD,    0,  'h1919, 0,      0);
        add_entry(CMD_LOAD,    0,  'h2A2A, 0,      -1);
        add_entry(CMD_CTRL_RD, 17, 0,      'h1F0F, 2);
    endtask

    // Returns on a rising edge with no run active or pending
    task automatic wait_idle();
        while (model_busy || run_pipe != '0)
            @(posedge clk_i);
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
            report_failure($sformatf("Timeout: run did not end within %0d cycles",
                                     cycle_limit));
    end

    // Reference model and checks, on the falling edge
    always @(negedge clk_i) begin
        if (mon_en) begin
            load_pipe = {load_pipe[1:0], msg_valid_i && (msg_i.cmd == CMD_LOAD)};
            rd_pipe   = {rd_pipe[2:0], msg_valid_i && (msg_i.cmd == CMD_CTRL_RD)};
            run_pipe  = {run_pipe[1:0], msg_valid_i && (msg_i.cmd == CMD_RUN)};
            run_exp   = {run_exp[1:0], cur_exp[0]};
            for (int i = 3; i > 0; i--)
                rd_data_pipe[i] = rd_data_pipe[i-1];

            // Count shows a load two cycles after it is seen here
            if (load_pipe[0])
                model_instrs.push_back(msg_i.data);
            if (load_pipe[2])
                model_count++;
            check_count(instr_count_o, instr_addr_t'(model_count));

            // Control block writes land before any later read
            if (msg_valid_i && (msg_i.cmd == CMD_CTRL_WR))
                model_ctrl[msg_i.addr] = ctrl_t'(msg_i.data);
            if (rd_pipe[0]) begin
                rd_data_pipe[0] = model_ctrl[msg_i.addr];
                if (model_ctrl[msg_i.addr] !== cur_exp)
                    report_failure("Table read value disagrees with the reference model");
            end
            if (ctrl_rd_valid_o !== rd_pipe[3])
                report_failure($sformatf("ERROR: ctrl_rd_valid_o got 0x%h expected 0x%h",
                                         ctrl_rd_valid_o, rd_pipe[3]));
            if (rd_pipe[3])
                check_ctrl(ctrl_rd_data_o, rd_data_pipe[3]);

            // RUN accepted on a non-zero count while idle
            run_new = 1'b0;
            if (run_pipe[2]) begin
                run_ok = (prev_count != 0) && !prev_busy;
                if (run_ok != run_exp[2])
                    report_failure("Table RUN acceptance disagrees with the reference model");
                if (run_ok) begin
                    model_busy = 1'b1;
                    run_new    = 1'b1;
                    next_idx   = 0;
                end
            end

            // Stream in load order, index with each instruction
            if (instr_valid_o) begin
                if (!model_busy)
                    report_failure("ERROR: instr_valid_o got 0x1 expected 0x0");
                if (next_idx >= model_count)
                    report_failure("Instruction delivered beyond the loaded count");
                check_instr(instr_o, instr_index_o, model_instrs[next_idx],
                            instr_addr_t'(next_idx));
                next_idx++;
            end

            // Fall of busy ends the run, all loads so far delivered
            if (model_busy && !run_new && busy_o === 1'b0) begin
                if (next_idx != model_count)
                    report_failure($sformatf("Run ended after %0d of %0d instructions",
                                             next_idx, model_count));
                model_busy = 1'b0;
            end else if (busy_o !== model_busy) begin
                report_failure($sformatf("ERROR: busy_o got 0x%h expected 0x%h",
                                         busy_o, model_busy));
            end

            prev_count = model_count;
            prev_busy  = model_busy;
        end
    end

    initial begin
        int gap_cycles;
        msg_i       <= '0;
        msg_valid_i <= 1'b0;
        cur_exp     <= '0;
        rst_i       <= 1'b1;
        build_table();
        cycle_limit = 8 * tbl.size() + 200;

        repeat (16) @(posedge clk_i);
        rst_i  <= 1'b0;
        // Reset state checked from the first falling edge on
        mon_en <= 1'b1;

        foreach (tbl[i]) begin
            if (tbl[i].msg.cmd == CMD_RUN && tbl[i].exp[0])
                wait_idle();
            msg_i       <= tbl[i].msg;
            cur_exp     <= tbl[i].exp;
            msg_valid_i <= 1'b1;
            @(posedge clk_i);
            msg_valid_i <= 1'b0;
            if (tbl[i].gap < 0)
                gap_cycles = int'($unsigned($random(seed)) % 4);
            else
                gap_cycles = tbl[i].gap;
            repeat (gap_cycles) @(posedge clk_i);
        end

        // Drain runs and pending reads
        do
            @(posedge clk_i);
        while (model_busy || load_pipe != '0 || rd_pipe != '0 || run_pipe != '0);
        repeat (2) @(posedge clk_i);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : node_top_tb

// File: vlog.f
design/node_cfg_pkg.sv
design/node_msg_pkg.sv
design/node_if.sv
design/node_ram.sv
design/node_store.sv
design/msg_decoder.sv
design/instr_sequencer.sv
design/node_top.sv
sim/node_checker.sv
sim/node_top_tb.sv

// File: Makefile
# Verilator build and run of the node local memory testbench

VERILATOR ?= verilator
TOP       ?= node_top_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
